/* src.f */
+incdir+src
src/pmrq_pkg.sv
src/miss_tag_alloc.sv
src/pending_mem_req_queue.sv
src/pmrq_wb_stage.sv
src/lsu_miss_path.sv
dv/tb_lsu_miss_path.sv

/* Bender.yml */
package:
  name: lsu_miss_path

sources:
  - include_dirs:
      - src
    files:
      - src/pmrq_pkg.sv
      - src/miss_tag_alloc.sv
      - src/pending_mem_req_queue.sv
      - src/pmrq_wb_stage.sv
      - src/lsu_miss_path.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - dv/tb_lsu_miss_path.sv

/* dv/tb_lsu_miss_path.sv */
////////////////////////////////////////////////////////////////////////////
// LSU miss path testbench
// Random requests, cancels and flushes against an in-order queue model,
// with an out-of-order memory responder and cycle exact output checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pmrq_config.svh"

module tb_lsu_miss_path;

    typedef struct packed {
        logic [`PMRQ_TAG_W-1:0] tag;
        logic                   fin;         // Response already seen
        pmrq_pkg::pmrq_entry_t  e;
    } model_t;

    typedef struct packed {
        logic [`PMRQ_TAG_W-1:0]  tag;
        logic [`PMRQ_ADDR_W-1:0] addr;
        logic [31:0]             ready;      // First cycle it may be answered
    } pend_t;

    logic clk_i = 1'b0;
    logic rstn_i = 1'b0;
    pmrq_pkg::mem_req_t    req = '0;
    pmrq_pkg::mem_resp_t   resp = '0;
    logic                  flush = 1'b0;
    logic                  cancel = 1'b0;
    pmrq_pkg::mem_miss_t   mem_miss_o;
    pmrq_pkg::pmrq_entry_t wb_o;
    logic                  full_o;

    integer seed = 32'h29b3;
    int     errors = 0;
    int     cycle = 0;
    int     wait_cnt;
    model_t mq[$];                           // Live requests in program order
    pend_t  os[$];                           // Misses not yet answered
    logic [`PMRQ_TAG_W-1:0] tag_ctr = '0;
    pmrq_pkg::mem_miss_t    exp_miss = '0;
    pmrq_pkg::pmrq_entry_t  exp_wb = '0;

    lsu_miss_path lsu_miss_path_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .req_i      (req),
        .resp_i     (resp),
        .flush_i    (flush),
        .cancel_i   (cancel),
        .mem_miss_o (mem_miss_o),
        .wb_o       (wb_o),
        .full_o     (full_o)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic [`PMRQ_DATA_W-1:0] resp_data(input logic [`PMRQ_TAG_W-1:0] tag,
                                                          input logic [`PMRQ_ADDR_W-1:0] addr);
        return `PMRQ_DATA_W'(tag) * 64'h9E37_79B9_7F4A_7C15 + `PMRQ_DATA_W'(addr);
    endfunction

    // Compare this cycle's outputs, then advance the model past the next edge
    task automatic step;
        logic exp_full;
        logic adv;
        logic acc;
        logic cnl;
        @(negedge clk_i);
        exp_full = (mq.size() >= `PMRQ_NUM_ENTRIES - `PMRQ_FULL_MARGIN) || flush;
        if (full_o !== exp_full) begin
            $display("FAIL @%0t: full_o %b, expected %b", $time, full_o, exp_full);
            errors++;
        end
        if (mem_miss_o.valid !== exp_miss.valid || (exp_miss.valid && mem_miss_o !== exp_miss)) begin
            $display("FAIL @%0t: mem_miss_o %h, expected %h", $time, mem_miss_o, exp_miss);
            errors++;
        end
        if (wb_o.valid !== exp_wb.valid || (exp_wb.valid && wb_o !== exp_wb)) begin
            $display("FAIL @%0t: wb_o %h, expected %h", $time, wb_o, exp_wb);
            errors++;
        end
        if (mem_miss_o.valid)
            os.push_back('{tag: mem_miss_o.tag, addr: mem_miss_o.addr,
                           ready: cycle + ($random(seed) & 15)});
        exp_miss = '0;
        exp_wb   = '0;
        if (flush) begin
            mq.delete();                     // Tag counter keeps going
        end else begin
            adv = (mq.size() != 0) && mq[0].fin;
            acc = req.valid && (mq.size() < `PMRQ_NUM_ENTRIES) && !cancel;
            cnl = cancel && !req.valid && (mq.size() > int'(adv));
            if (adv) begin
                exp_wb = mq[0].e;
                void'(mq.pop_front());
            end
            if (cnl) void'(mq.pop_back());
            for (int i = 0; i < mq.size(); i++) begin
                if (resp.valid && mq[i].tag == resp.tag) begin
                    mq[i].fin    = 1'b1;
                    mq[i].e.data = resp.data;
                end
            end
            if (acc) begin
                mq.push_back('{tag: tag_ctr, fin: 1'b0,
                               e: '{valid: 1'b1, op: req.op, addr: req.addr,
                                    prd: req.prd, data: req.store_data}});
                exp_miss = '{valid: 1'b1, tag: tag_ctr, op: req.op, addr: req.addr};
                tag_ctr++;
            end
        end
        @(posedge clk_i);
        #1;
        cycle++;
    endtask

    task automatic drive_next(input bit allow_req);
        logic [31:0] r;
        int idx;
        r      = $random(seed);
        req    = '0;
        resp   = '0;
        flush  = 1'b0;
        cancel = 1'b0;
        if (allow_req) begin
            flush  = (r[7:0] == 8'd0);
            cancel = (r[11:8] == 4'd0);
            // Mostly honour full_o but now and then push on to reach the depth
            if ((mq.size() < `PMRQ_NUM_ENTRIES - `PMRQ_FULL_MARGIN && r[13:12] != 2'd0)
                || r[17:14] == 4'd0) begin
                req.valid      = 1'b1;
                req.op         = pmrq_pkg::mem_op_e'(2'($unsigned($random(seed)) % 3));
                req.addr       = `PMRQ_ADDR_W'({$random(seed), $random(seed)});
                req.store_data = {$random(seed), $random(seed)};
                req.prd        = 7'($random(seed));
            end
        end
        if (os.size() != 0 && r[18]) begin
            idx = $unsigned($random(seed)) % os.size();
            if (os[idx].ready <= cycle) begin    // Answer a random old enough miss
                resp = '{valid: 1'b1, tag: os[idx].tag,
                         data: resp_data(os[idx].tag, os[idx].addr)};
                os.delete(idx);
            end
        end
    endtask

    initial begin
        repeat (4) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        repeat (3000) begin
            drive_next(1'b1);
            step();
        end
        wait_cnt = 0;
        while ((mq.size() != 0 || os.size() != 0) && wait_cnt < 2000) begin
            drive_next(1'b0);
            step();
            wait_cnt++;
        end
        if (wait_cnt >= 2000) begin
            $display("Timeout: queue still holds %0d entries after 2000 cycles", mq.size());
            errors++;
        end
        drive_next(1'b0);
        repeat (2) step();                   // Let the last writeback show
        $display("Run finished after %0d cycles with %0d errors", cycle, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* src/lsu_miss_path.sv */
////////////////////////////////////////////////////////////////////////////
// LSU miss path
// Tags incoming memory operations, sends misses out, waits for the
// tagged responses and writes results back in program order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pmrq_config.svh"

module lsu_miss_path (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  pmrq_pkg::mem_req_t     req_i,
    input  pmrq_pkg::mem_resp_t    resp_i,
    input  logic                   flush_i,
    input  logic                   cancel_i,
    output pmrq_pkg::mem_miss_t    mem_miss_o,
    output pmrq_pkg::pmrq_entry_t  wb_o,
    output logic                   full_o
);

    logic                   accept;
    logic [`PMRQ_TAG_W-1:0] cur_tag;
    pmrq_pkg::pmrq_entry_t  head_entry;
    logic                   advance_head;

    miss_tag_alloc miss_tag_alloc_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .req_i      (req_i),
        .accept_i   (accept),
        .flush_i    (flush_i),
        .tag_o      (cur_tag),
        .mem_miss_o (mem_miss_o)
    );

    pending_mem_req_queue pending_mem_req_queue_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_i          (req_i),
        .tag_i          (cur_tag),
        .resp_i         (resp_i),
        .flush_i        (flush_i),
        .cancel_i       (cancel_i),
        .advance_head_i (advance_head),
        .accept_o       (accept),
        .head_entry_o   (head_entry),
        .full_o         (full_o)
    );

    pmrq_wb_stage pmrq_wb_stage_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .head_entry_i   (head_entry),
        .advance_head_o (advance_head),
        .wb_o           (wb_o)
    );

endmodule

/* src/pmrq_wb_stage.sv */
////////////////////////////////////////////////////////////////////////////
// Miss path writeback stage
// Registers the finished head entry as the writeback output and tells
// the queue to move its head on
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pmrq_wb_stage (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,
    input  pmrq_pkg::pmrq_entry_t  head_entry_i,
    output logic                   advance_head_o,
    output pmrq_pkg::pmrq_entry_t  wb_o
);

    logic                  wb_valid_q;
    pmrq_pkg::pmrq_entry_t wb_data_q;

    // No back-pressure, a finished head leaves every cycle
    assign advance_head_o = head_entry_i.valid && !flush_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= advance_head_o;   // Flush already masked above
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance_head_o) begin
            wb_data_q <= head_entry_i;
        end
    end

    always_comb begin
        wb_o       = wb_data_q;
        wb_o.valid = wb_valid_q;
    end

endmodule

/* src/pending_mem_req_queue.sv */
////////////////////////////////////////////////////////////////////////////
// Pending memory request queue
// Circular queue of loads, stores and atomics waiting on a cache miss.
// Responses are matched by tag and mark entries finished; the oldest
// entry is offered for writeback once it is finished. Supports flush
// and removal of the youngest entry
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pmrq_config.svh"

module pending_mem_req_queue (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  pmrq_pkg::mem_req_t      req_i,
    input  logic [`PMRQ_TAG_W-1:0]  tag_i,          // Tag given to req_i
    input  pmrq_pkg::mem_resp_t     resp_i,
    input  logic                    flush_i,
    input  logic                    cancel_i,       // Remove the youngest entry
    input  logic                    advance_head_i, // Head was written back
    output logic                    accept_o,
    output pmrq_pkg::pmrq_entry_t   head_entry_o,   // Valid only when head is finished
    output logic                    full_o
);

    localparam int PTR_W = $clog2(`PMRQ_NUM_ENTRIES);
    localparam int CNT_W = PTR_W + 1;

    logic [PTR_W-1:0] head_q;   // Oldest live entry
    logic [PTR_W-1:0] tail_q;   // Next free slot
    logic [CNT_W-1:0] count_q;

    logic write_en;
    logic advance_en;
    logic cancel_en;

    pmrq_pkg::pmrq_entry_t      entry_table [`PMRQ_NUM_ENTRIES];
    logic [`PMRQ_TAG_W-1:0]     tag_table   [`PMRQ_NUM_ENTRIES];
    logic [`PMRQ_NUM_ENTRIES-1:0] finish_q;

    // A request together with a cancel does nothing
    assign write_en = req_i.valid && (count_q < `PMRQ_NUM_ENTRIES) && !cancel_i && !flush_i;

    assign advance_en = advance_head_i && (count_q != '0);

    // An entry leaving through writeback this cycle cannot be cancelled too
    assign cancel_en = cancel_i && !req_i.valid && !flush_i
                       && (count_q > CNT_W'(advance_en));

    assign accept_o = write_en;

    // Payload tables
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `PMRQ_NUM_ENTRIES; i++) begin
            if (resp_i.valid && (tag_table[i] == resp_i.tag)) begin
                entry_table[i].data <= resp_i.data;
            end
        end
        if (write_en) begin
            entry_table[tail_q] <= '{valid: 1'b1,
                                     op:    req_i.op,
                                     addr:  req_i.addr,
                                     prd:   req_i.prd,
                                     data:  req_i.store_data};  // Replaced by the response
            tag_table[tail_q]   <= tag_i;
        end
    end

    // Finish bits, a new write wins over a stale match
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            finish_q <= '0;
        end else begin
            for (int i = 0; i < `PMRQ_NUM_ENTRIES; i++) begin
                if (resp_i.valid && (tag_table[i] == resp_i.tag)) begin
                    finish_q[i] <= 1'b1;
                end
            end
            if (write_en) begin
                finish_q[tail_q] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + PTR_W'(advance_en);
            tail_q  <= tail_q + PTR_W'(write_en) - PTR_W'(cancel_en);
            count_q <= count_q + CNT_W'(write_en) - CNT_W'(advance_en)
                       - CNT_W'(cancel_en);
        end
    end

    always_comb begin
        if ((count_q != '0) && finish_q[head_q]) begin
            head_entry_o = entry_table[head_q];
        end else begin
            head_entry_o = '0;
        end
    end

    // Raised early so that requests already in flight still find room
    assign full_o = (count_q >= (`PMRQ_NUM_ENTRIES - `PMRQ_FULL_MARGIN)) || flush_i || !rstn_i;

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        count_q <= `PMRQ_NUM_ENTRIES)
        else $error("pending_mem_req_queue: count above depth");

    // Writeback stage must only retire a live entry
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        advance_head_i |-> (count_q != '0))
        else $error("pending_mem_req_queue: head advanced on empty queue");

endmodule

/* src/miss_tag_alloc.sv */
////////////////////////////////////////////////////////////////////////////
// Miss tag allocator
// Hands out a tag per accepted request from a wrapping counter and
// registers the outbound memory request for one cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pmrq_config.svh"

module miss_tag_alloc (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  pmrq_pkg::mem_req_t      req_i,
    input  logic                    accept_i,     // Queue took the request
    input  logic                    flush_i,
    output logic [`PMRQ_TAG_W-1:0]  tag_o,        // Tag for the request of this cycle
    output pmrq_pkg::mem_miss_t     mem_miss_o
);

    logic [`PMRQ_TAG_W-1:0]  tag_q;
    logic                    miss_valid_q;
    logic [`PMRQ_TAG_W-1:0]  miss_tag_q;
    pmrq_pkg::mem_op_e       miss_op_q;
    logic [`PMRQ_ADDR_W-1:0] miss_addr_q;

    // Tag counter never steps back on flush or cancel
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            tag_q <= '0;
        end else if (accept_i) begin
            tag_q <= tag_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            miss_valid_q <= 1'b0;
        end else if (flush_i) begin
            miss_valid_q <= 1'b0;     // Drop a request still on its way out
        end else begin
            miss_valid_q <= accept_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            miss_tag_q  <= tag_q;
            miss_op_q   <= req_i.op;
            miss_addr_q <= req_i.addr;
        end
    end

    assign tag_o = tag_q;

    always_comb begin
        mem_miss_o.valid = miss_valid_q;
        mem_miss_o.tag   = miss_tag_q;
        mem_miss_o.op    = miss_op_q;
        mem_miss_o.addr  = miss_addr_q;
    end

    // A miss leaves only in the cycle right after the queue accepted it
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !accept_i |=> !mem_miss_o.valid)
        else $error("miss_tag_alloc: miss sent without an accepted request");

endmodule

/* src/pmrq_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// LSU miss path types
// Operation encoding and the request, miss, response and queue entry
// structures passed between the miss path blocks
////////////////////////////////////////////////////////////////////////////

`include "pmrq_config.svh"

package pmrq_pkg;

    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_AMO   = 2'd2
    } mem_op_e;

    // Request coming from the issue side, operands already read
    typedef struct packed {
        logic                    valid;
        mem_op_e                 op;
        logic [`PMRQ_ADDR_W-1:0] addr;
        logic [`PMRQ_DATA_W-1:0] store_data;
        logic [6:0]              prd;         // Destination physical register
    } mem_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`PMRQ_TAG_W-1:0]  tag;
        mem_op_e                 op;
        logic [`PMRQ_ADDR_W-1:0] addr;
    } mem_miss_t;

    typedef struct packed {
        logic                    valid;
        logic [`PMRQ_TAG_W-1:0]  tag;
        logic [`PMRQ_DATA_W-1:0] data;
    } mem_resp_t;

    // Load/AMO data, or the memory echo for a store
    typedef struct packed {
        logic                    valid;
        mem_op_e                 op;
        logic [`PMRQ_ADDR_W-1:0] addr;
        logic [6:0]              prd;
        logic [`PMRQ_DATA_W-1:0] data;
    } pmrq_entry_t;

endpackage

/* src/pmrq_config.svh */
////////////////////////////////////////////////////////////////////////////
// LSU miss path configuration
// Queue depth, field widths and the full threshold margin shared by the
// pending memory request queue and its neighbours
////////////////////////////////////////////////////////////////////////////

`ifndef PMRQ_CONFIG_SVH
`define PMRQ_CONFIG_SVH

`define PMRQ_NUM_ENTRIES 8     // Power of two, at least 4
`define PMRQ_TAG_W       7     // Wraps well beyond the queue depth
`define PMRQ_ADDR_W      40
`define PMRQ_DATA_W      64

// Free entries left when full_o rises
`define PMRQ_FULL_MARGIN 3

`endif
